/* hw/bp_pkg.sv */
`default_nettype none

package bp_pkg;

	// ========================================
	// sizes
	// ========================================

	// pc and instruction word width
	localparam int XLEN = 32;
	// imem and weight table index, taken from pc[9:2]
	localparam int IMEM_AW = 8;
	// default history length, one weight per history bit
	localparam int GHR_LEN = 8;
	// default signed weight width
	localparam int WEIGHT_W = 8;
	// stack index width, 16 entries
	localparam int RAS_AW = 4;

	// ========================================
	// predecoded target select
	// ========================================

	localparam logic [1:0] SEL_SEQ = 2'b00;
	localparam logic [1:0] SEL_RET = 2'b01;
	localparam logic [1:0] SEL_IMM16 = 2'b10;
	localparam logic [1:0] SEL_IMM26 = 2'b11;

	// hint bits sit above the register field
	typedef struct packed {
		logic [1:0] target_sel;
		logic uncond;
		logic spare;
		logic call;
		logic [4:0] rs;
		logic [15:0] imm16;
		logic [5:0] op;
	} i_form_t;

	// absolute jump layout
	typedef struct packed {
		logic [25:0] imm26;
		logic [5:0] op;
	} j_form_t;

	// same fetched word, two decodings
	typedef union packed {
		i_form_t i_form;
		j_form_t j_form;
	} insn_t;

endpackage

`default_nettype wire

/* hw/ras_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ras_if;
	import bp_pkg::*;

	// stack updates from the fetch side
	logic push;
	logic pop;
	logic [XLEN-1:0] push_addr;

	// restore from execute after a flush
	logic recover;
	logic [RAS_AW-1:0] recover_index;

	// stack state back to fetch and the top level
	logic [XLEN-1:0] top_addr;
	logic [RAS_AW-1:0] index;

	modport ctrl (
		output push, pop, push_addr, recover, recover_index,
		input top_addr
	);

	modport stack (
		input push, pop, push_addr, recover, recover_index,
		output top_addr, index
	);

endinterface

`default_nettype wire

/* hw/insn_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_mem (
	input wire logic clk,
	input wire logic reset,
	input wire logic [bp_pkg::IMEM_AW-1:0] rd_addr,
	output bp_pkg::insn_t rd_data,
	input wire logic imem_wr_req,
	input wire logic [bp_pkg::IMEM_AW-1:0] imem_wr_addr,
	input wire logic [bp_pkg::XLEN-1:0] imem_wr_data,
	output logic imem_wr_ack
);
	import bp_pkg::*;

	localparam int DEPTH = 2 ** IMEM_AW;

	logic [XLEN-1:0] mem [DEPTH];
	// one write per handshake, only while ack is still low
	logic wr_fire;

	assign wr_fire = imem_wr_req & ~imem_wr_ack;

	// ========================================
	// load handshake
	// ========================================

	// ack follows req with one clock of delay in both directions
	always_ff @(posedge clk) begin
		if (reset) begin
			imem_wr_ack <= 1'b0;
		end else if (wr_fire) begin
			imem_wr_ack <= 1'b1;
		end else if (!imem_wr_req && imem_wr_ack) begin
			imem_wr_ack <= 1'b0;
		end
	end

	// ========================================
	// storage
	// ========================================

	// registered read, word arrives with pc_r in fetch
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[imem_wr_addr] <= imem_wr_data;
		end
		rd_data <= mem[rd_addr];
	end

	// host keeps the address until ack has come back
	a_wr_addr_stable: assert property (@(posedge clk) disable iff (reset)
		imem_wr_req && !imem_wr_ack |=> !imem_wr_req || $stable(imem_wr_addr));

endmodule

`default_nettype wire

/* hw/return_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module return_stack (
	input wire logic clk,
	input wire logic reset,
	ras_if.stack ras
);
	import bp_pkg::*;

	localparam int DEPTH = 2 ** RAS_AW;

	// circular, overflow just wraps over the oldest entry
	logic [XLEN-1:0] entries [DEPTH];
	logic [RAS_AW-1:0] index_r;
	logic [RAS_AW-1:0] index_inc;
	logic [RAS_AW-1:0] index_dec;

	assign index_inc = index_r + 1'b1;
	assign index_dec = index_r - 1'b1;

	// ========================================
	// stack pointer
	// ========================================

	// recovery wins over anything fetch asks for
	always_ff @(posedge clk) begin
		if (reset) begin
			index_r <= '0;
		end else if (ras.recover) begin
			index_r <= ras.recover_index;
		end else if (ras.push) begin
			index_r <= index_inc;
		end else if (ras.pop) begin
			index_r <= index_dec;
		end
	end

	// ========================================
	// entries
	// ========================================

	// push lands one slot above the current top
	always_ff @(posedge clk) begin
		if (!ras.recover && ras.push) begin
			entries[index_inc] <= ras.push_addr;
		end
	end

	// top read is combinational, fetch needs it same cycle
	assign ras.top_addr = entries[index_r];
	assign ras.index = index_r;

	// call words never carry the return select
	a_no_push_pop: assert property (@(posedge clk) disable iff (reset)
		!(ras.push && ras.pop));

endmodule

`default_nettype wire

/* hw/perceptron_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module perceptron_predictor #(
	parameter int GHR_LEN = bp_pkg::GHR_LEN,
	parameter int WEIGHT_W = bp_pkg::WEIGHT_W
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [bp_pkg::IMEM_AW-1:0] lookup_idx,
	input wire logic update_valid,
	input wire logic stall,
	input wire logic [bp_pkg::XLEN-1:0] update_pc,
	input wire logic update_dir,
	output logic pred_dir
);
	import bp_pkg::*;

	localparam int TBL_DEPTH = 2 ** IMEM_AW;
	// room for GHR_LEN weights of either sign
	localparam int SUM_W = WEIGHT_W + $clog2(GHR_LEN) + 1;
	localparam logic signed [WEIGHT_W-1:0] W_MAX = (1 << (WEIGHT_W - 1)) - 1;
	localparam logic signed [WEIGHT_W-1:0] W_MIN = -W_MAX;
	localparam logic signed [WEIGHT_W-1:0] W_ONE = 1;

	logic signed [WEIGHT_W-1:0] weights [TBL_DEPTH][GHR_LEN];
	logic signed [WEIGHT_W-1:0] w_rd [GHR_LEN];
	logic [GHR_LEN-1:0] ghr;
	logic signed [SUM_W-1:0] weighted_sum;

	// training stage registers
	logic accept;
	logic upd_vld;
	logic [IMEM_AW-1:0] upd_idx;
	logic upd_dir;
	logic [GHR_LEN-1:0] upd_hist;

	// one step toward agreement, clamped symmetric
	function automatic logic signed [WEIGHT_W-1:0] step_weight(
		input logic signed [WEIGHT_W-1:0] w,
		input logic agree
	);
		if (agree) begin
			return (w == W_MAX) ? w : w + W_ONE;
		end
		return (w == W_MIN) ? w : w - W_ONE;
	endfunction

	// ========================================
	// lookup
	// ========================================

	// row read with fetch_pc, used next cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			w_rd <= '{default: '0};
		end else begin
			w_rd <= weights[lookup_idx];
		end
	end

	// history bit 1 adds the weight, 0 subtracts it
	always_comb begin
		weighted_sum = '0;
		for (int g = 0; g < GHR_LEN; g++) begin
			if (ghr[g]) begin
				weighted_sum = weighted_sum + SUM_W'(w_rd[g]);
			end else begin
				weighted_sum = weighted_sum - SUM_W'(w_rd[g]);
			end
		end
	end

	// zero counts as taken
	assign pred_dir = ~weighted_sum[SUM_W-1];

	// ========================================
	// training
	// ========================================

	assign accept = update_valid & ~stall;

	// stage 1, shift history and remember what to train
	always_ff @(posedge clk) begin
		if (reset) begin
			ghr <= '0;
			upd_vld <= 1'b0;
		end else begin
			upd_vld <= accept;
			if (accept) begin
				ghr <= {ghr[GHR_LEN-2:0], update_dir};
			end
		end
	end

	// history captured before the shift
	always_ff @(posedge clk) begin
		if (accept) begin
			upd_idx <= update_pc[IMEM_AW+1:2];
			upd_dir <= update_dir;
			upd_hist <= ghr;
		end
	end

	// stage 2, read-modify-write of the whole row
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int e = 0; e < TBL_DEPTH; e++) begin
				for (int g = 0; g < GHR_LEN; g++) begin
					weights[e][g] <= '0;
				end
			end
		end else if (upd_vld) begin
			for (int g = 0; g < GHR_LEN; g++) begin
				weights[upd_idx][g] <= step_weight(weights[upd_idx][g], upd_hist[g] == upd_dir);
			end
		end
	end

	// every row ever read stays inside the clamp
	for (genvar g = 0; g < GHR_LEN; g++) begin : g_range_chk
		a_weight_range: assert property (@(posedge clk) disable iff (reset)
			(w_rd[g] >= W_MIN) && (w_rd[g] <= W_MAX));
	end

endmodule

`default_nettype wire

/* hw/fetch_next_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_next_pc (
	input wire logic clk,
	input wire logic reset,
	input wire bp_pkg::insn_t insn,
	input wire logic pred_dir,
	input wire logic fetch_redirect,
	input wire logic [bp_pkg::XLEN-1:0] fetch_redirect_pc,
	input wire logic ras_recover,
	input wire logic [bp_pkg::RAS_AW-1:0] ras_recover_index,
	ras_if.ctrl ras,
	output logic [bp_pkg::XLEN-1:0] fetch_pc
);
	import bp_pkg::*;

	// pc of the word now on insn
	logic [XLEN-1:0] pc_r;
	// low in the reset-release cycle while no word has been read yet
	logic insn_valid;

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] imm16_sext;
	logic [XLEN-1:0] imm16_sum;
	logic [XLEN-1:0] target_imm16;
	logic [XLEN-1:0] target_imm26;
	logic taken_eff;
	logic live;

	// ========================================
	// targets
	// ========================================

	assign pc_plus4 = pc_r + 32'd4;
	assign imm16_sext = {{16{insn.i_form.imm16[15]}}, insn.i_form.imm16};
	assign imm16_sum = pc_plus4 + imm16_sext;
	// word aligned with the byte offset dropped
	assign target_imm16 = {imm16_sum[XLEN-1:2], 2'b00};
	// region bits from the current pc
	assign target_imm26 = {pc_r[XLEN-1:28], insn.j_form.imm26, 2'b00};

	assign taken_eff = insn.i_form.uncond | pred_dir;

	// ========================================
	// next pc select
	// ========================================

	always_comb begin
		if (!insn_valid) begin
			fetch_pc = '0;
		end else if (fetch_redirect) begin
			fetch_pc = fetch_redirect_pc;
		end else if (taken_eff) begin
			case (insn.i_form.target_sel)
				SEL_RET: fetch_pc = ras.top_addr;
				SEL_IMM16: fetch_pc = target_imm16;
				SEL_IMM26: fetch_pc = target_imm26;
				default: fetch_pc = pc_plus4;
			endcase
		end else begin
			fetch_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_r <= '0;
			insn_valid <= 1'b0;
		end else begin
			pc_r <= fetch_pc;
			insn_valid <= 1'b1;
		end
	end

	// ========================================
	// stack control
	// ========================================

	// a redirected word is squashed and leaves the stack alone
	assign live = insn_valid & ~fetch_redirect;

	assign ras.push = live & insn.i_form.call;
	assign ras.push_addr = pc_plus4;
	assign ras.pop = live & taken_eff & (insn.i_form.target_sel == SEL_RET);
	assign ras.recover = ras_recover;
	assign ras.recover_index = ras_recover_index;

endmodule

`default_nettype wire

/* hw/bp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_top #(
	parameter int GHR_LEN = bp_pkg::GHR_LEN,
	parameter int WEIGHT_W = bp_pkg::WEIGHT_W
) (
	input wire logic clk,
	input wire logic reset,
	// imem load, four-phase
	input wire logic imem_wr_req,
	input wire logic [bp_pkg::IMEM_AW-1:0] imem_wr_addr,
	input wire logic [bp_pkg::XLEN-1:0] imem_wr_data,
	output logic imem_wr_ack,
	// fetch side
	output logic [bp_pkg::XLEN-1:0] fetch_pc,
	output logic pred_dir,
	output logic [bp_pkg::RAS_AW-1:0] ras_index,
	input wire logic fetch_redirect,
	input wire logic [bp_pkg::XLEN-1:0] fetch_redirect_pc,
	// execute side
	input wire logic update_valid,
	input wire logic [bp_pkg::XLEN-1:0] update_pc,
	input wire logic update_dir,
	input wire logic update_stall,
	input wire logic ras_recover,
	input wire logic [bp_pkg::RAS_AW-1:0] ras_recover_index
);
	import bp_pkg::*;

	insn_t insn;
	// pc[9:2], shared by imem and weight table
	logic [IMEM_AW-1:0] fetch_idx;

	ras_if ras_bus ();

	assign fetch_idx = fetch_pc[IMEM_AW+1:2];
	assign ras_index = ras_bus.index;

	insn_mem i_insn_mem (
		.clk(clk),
		.reset(reset),
		.rd_addr(fetch_idx),
		.rd_data(insn),
		.imem_wr_req(imem_wr_req),
		.imem_wr_addr(imem_wr_addr),
		.imem_wr_data(imem_wr_data),
		.imem_wr_ack(imem_wr_ack)
	);

	return_stack i_return_stack (
		.clk(clk),
		.reset(reset),
		.ras(ras_bus.stack)
	);

	perceptron_predictor #(
		.GHR_LEN(GHR_LEN),
		.WEIGHT_W(WEIGHT_W)
	) i_perceptron_predictor (
		.clk(clk),
		.reset(reset),
		.lookup_idx(fetch_idx),
		.update_valid(update_valid),
		.stall(update_stall),
		.update_pc(update_pc),
		.update_dir(update_dir),
		.pred_dir(pred_dir)
	);

	fetch_next_pc i_fetch_next_pc (
		.clk(clk),
		.reset(reset),
		.insn(insn),
		.pred_dir(pred_dir),
		.fetch_redirect(fetch_redirect),
		.fetch_redirect_pc(fetch_redirect_pc),
		.ras_recover(ras_recover),
		.ras_recover_index(ras_recover_index),
		.ras(ras_bus.ctrl),
		.fetch_pc(fetch_pc)
	);

endmodule

`default_nettype wire

/* testbench/tb_bp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bp_top;
	import bp_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int IMEM_DEPTH = 2 ** IMEM_AW;
	localparam int W_LIM = (1 << (WEIGHT_W - 1)) - 1;
	// cycles a handshake phase may take before it counts as stuck
	localparam int HS_LIMIT = 16;

	// ========================================
	// test lengths in cycles
	// ========================================

	localparam int SEQ_RUN = 24;
	localparam int REDIR_RUN = 40;
	localparam int JUMP_RUN = 30;
	localparam int CALL_RUN = 40;
	localparam int BURST_RUN = 300;
	localparam int RAND_RUN = 300;
	localparam int STALL_RUN = 60;
	localparam int PROG_WORDS = 11;
	// loads cost up to three cycles a word plus a few for each park
	localparam int TEST_CYCLES = 2 * RESET_CYCLES + 3 * (IMEM_DEPTH + PROG_WORDS)
		+ SEQ_RUN + REDIR_RUN + JUMP_RUN + 3 * CALL_RUN + BURST_RUN + RAND_RUN
		+ STALL_RUN + 200;
	localparam longint WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	logic clk;
	logic reset;
	logic imem_wr_req;
	logic [IMEM_AW-1:0] imem_wr_addr;
	logic [XLEN-1:0] imem_wr_data;
	logic imem_wr_ack;
	logic [XLEN-1:0] fetch_pc;
	logic pred_dir;
	logic [RAS_AW-1:0] ras_index;
	logic fetch_redirect;
	logic [XLEN-1:0] fetch_redirect_pc;
	logic update_valid;
	logic [XLEN-1:0] update_pc;
	logic update_dir;
	logic update_stall;
	logic ras_recover;
	logic [RAS_AW-1:0] ras_recover_index;

	int pc_errs = 0;
	int dir_errs = 0;
	int idx_errs = 0;
	int hs_errs = 0;
	int total_errs;

	bp_top #(
		.GHR_LEN(GHR_LEN),
		.WEIGHT_W(WEIGHT_W)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.imem_wr_req(imem_wr_req),
		.imem_wr_addr(imem_wr_addr),
		.imem_wr_data(imem_wr_data),
		.imem_wr_ack(imem_wr_ack),
		.fetch_pc(fetch_pc),
		.pred_dir(pred_dir),
		.ras_index(ras_index),
		.fetch_redirect(fetch_redirect),
		.fetch_redirect_pc(fetch_redirect_pc),
		.update_valid(update_valid),
		.update_pc(update_pc),
		.update_dir(update_dir),
		.update_stall(update_stall),
		.ras_recover(ras_recover),
		.ras_recover_index(ras_recover_index)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================

	// image of what was loaded into imem
	logic [XLEN-1:0] img [IMEM_DEPTH];
	logic [XLEN-1:0] m_pc;
	logic m_valid;
	logic [XLEN-1:0] m_insn;
	logic [XLEN-1:0] m_ras [2 ** RAS_AW];
	logic [RAS_AW-1:0] m_idx;
	logic [RAS_AW-1:0] m_idx_up;
	logic [GHR_LEN-1:0] m_ghr;
	int m_w [IMEM_DEPTH][GHR_LEN];
	int m_wrd [GHR_LEN];
	// training stage
	logic m_uv;
	logic [IMEM_AW-1:0] m_uidx;
	logic m_udir;
	logic [GHR_LEN-1:0] m_uhist;
	// expected outputs and stack controls
	int m_sum;
	logic exp_dir;
	logic [XLEN-1:0] exp_pc;
	logic [IMEM_AW-1:0] exp_idx;
	logic [1:0] m_sel;
	logic m_taken;
	logic m_live;
	logic m_push;
	logic m_pop;

	// hint fields straight from the word layout
	assign m_sel = m_insn[31:30];
	assign m_taken = m_insn[29] | exp_dir;
	assign m_live = m_valid & ~fetch_redirect;
	assign m_push = m_live & m_insn[27];
	assign m_pop = m_live & m_taken & (m_sel == SEL_RET);
	assign m_idx_up = m_idx + 1'b1;
	assign exp_idx = exp_pc[IMEM_AW+1:2];

	// weight added for history 1 and subtracted for 0
	always_comb begin
		m_sum = 0;
		for (int g = 0; g < GHR_LEN; g++) begin
			if (m_ghr[g]) begin
				m_sum = m_sum + m_wrd[g];
			end else begin
				m_sum = m_sum - m_wrd[g];
			end
		end
	end

	assign exp_dir = (m_sum >= 0);

	always_comb begin
		if (!m_valid) begin
			exp_pc = '0;
		end else if (fetch_redirect) begin
			exp_pc = fetch_redirect_pc;
		end else if (m_taken && m_sel == SEL_RET) begin
			exp_pc = m_ras[m_idx];
		end else if (m_taken && m_sel == SEL_IMM16) begin
			exp_pc = (m_pc + 32'd4 + {{16{m_insn[21]}}, m_insn[21:6]}) & ~32'h3;
		end else if (m_taken && m_sel == SEL_IMM26) begin
			exp_pc = {m_pc[31:28], m_insn[31:6], 2'b00};
		end else begin
			exp_pc = m_pc + 32'd4;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			m_pc <= '0;
			m_valid <= 1'b0;
			m_idx <= '0;
			m_ghr <= '0;
			m_uv <= 1'b0;
			for (int e = 0; e < IMEM_DEPTH; e++) begin
				for (int g = 0; g < GHR_LEN; g++) begin
					m_w[e][g] <= 0;
				end
			end
			for (int g = 0; g < GHR_LEN; g++) begin
				m_wrd[g] <= 0;
			end
		end else begin
			m_pc <= exp_pc;
			m_valid <= 1'b1;
			// row read now sees old weights if written this cycle
			for (int g = 0; g < GHR_LEN; g++) begin
				m_wrd[g] <= m_w[exp_idx][g];
			end
			if (ras_recover) begin
				m_idx <= ras_recover_index;
			end else if (m_push) begin
				m_ras[m_idx_up] <= m_pc + 32'd4;
				m_idx <= m_idx_up;
			end else if (m_pop) begin
				m_idx <= m_idx - 1'b1;
			end
			m_uv <= update_valid & ~update_stall;
			if (update_valid && !update_stall) begin
				m_uidx <= update_pc[IMEM_AW+1:2];
				m_udir <= update_dir;
				m_uhist <= m_ghr;
				m_ghr <= {m_ghr[GHR_LEN-2:0], update_dir};
			end
			// one step per weight clamped at +-W_LIM
			if (m_uv) begin
				for (int g = 0; g < GHR_LEN; g++) begin
					if (m_uhist[g] == m_udir) begin
						if (m_w[m_uidx][g] < W_LIM) begin
							m_w[m_uidx][g] <= m_w[m_uidx][g] + 1;
						end
					end else if (m_w[m_uidx][g] > -W_LIM) begin
						m_w[m_uidx][g] <= m_w[m_uidx][g] - 1;
					end
				end
			end
		end
		m_insn <= img[exp_idx];
	end

	// ========================================
	// checks
	// ========================================

	a_fetch_pc: assert property (@(posedge clk) disable iff (reset) fetch_pc == exp_pc)
		else begin
			pc_errs++;
			$display("error: fetch_pc = %h, expected %h", $sampled(fetch_pc), $sampled(exp_pc));
		end

	a_pred_dir: assert property (@(posedge clk) disable iff (reset) pred_dir == exp_dir)
		else begin
			dir_errs++;
			$display("error: pred_dir = %h, expected %h", $sampled(pred_dir), $sampled(exp_dir));
		end

	a_ras_index: assert property (@(posedge clk) disable iff (reset) ras_index == m_idx)
		else begin
			idx_errs++;
			$display("error: ras_index = %h, expected %h", $sampled(ras_index), $sampled(m_idx));
		end

	// four-phase order on the load port
	a_ack_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(imem_wr_ack) |-> $past(imem_wr_req))
		else begin
			hs_errs++;
			$display("imem_wr_ack rose without a pending request");
		end

	a_ack_fall: assert property (@(posedge clk) disable iff (reset)
		$fell(imem_wr_ack) |-> !$past(imem_wr_req))
		else begin
			hs_errs++;
			$display("imem_wr_ack fell while the request was still high");
		end

	a_ack_hold: assert property (@(posedge clk) disable iff (reset)
		imem_wr_req && imem_wr_ack |=> imem_wr_ack)
		else begin
			hs_errs++;
			$display("imem_wr_ack dropped before the request was released");
		end

	// ========================================
	// stimulus helpers
	// ========================================

	function automatic logic [XLEN-1:0] fill_word(input logic [IMEM_AW-1:0] a);
		// fall-through word with every field tied to the address
		return {SEL_SEQ, 3'b000, a[4:0], ~a, a, a[5:0]};
	endfunction

	function automatic logic [XLEN-1:0] branch_word(
		input logic [1:0] sel,
		input logic uncond,
		input logic call,
		input logic [15:0] imm16
	);
		return {sel, uncond, 1'b0, call, 5'd0, imm16, 6'h04};
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		idle_cycles(RESET_CYCLES);
		reset = 1'b0;
	endtask

	// one four-phase write started on a falling edge
	task automatic load_word(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] data);
		int waited;
		imem_wr_addr = pc[IMEM_AW+1:2];
		imem_wr_data = data;
		imem_wr_req = 1'b1;
		img[pc[IMEM_AW+1:2]] = data;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!imem_wr_ack && waited < HS_LIMIT);
		if (!imem_wr_ack) begin
			hs_errs++;
			$display("no imem_wr_ack for the write to pc %h", pc);
		end
		// host sometimes keeps req up for a cycle after ack
		idle_cycles($urandom % 2);
		imem_wr_req = 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (imem_wr_ack && waited < HS_LIMIT);
		if (imem_wr_ack) begin
			hs_errs++;
			$display("imem_wr_ack stayed high after the request dropped");
		end
	endtask

	// hold fetch on one pc through redirect
	task automatic park_fetch(input logic [XLEN-1:0] pc);
		fetch_redirect = 1'b1;
		fetch_redirect_pc = pc;
		idle_cycles(2);
	endtask

	// word at the parked pc is read by now
	task automatic resume_fetch();
		idle_cycles(3);
		fetch_redirect = 1'b0;
	endtask

	task automatic recover_stack(input logic [RAS_AW-1:0] idx);
		ras_recover = 1'b1;
		ras_recover_index = idx;
		@(negedge clk);
		ras_recover = 1'b0;
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		void'($urandom(32'hff9));
		reset = 1'b1;
		imem_wr_req = 1'b0;
		imem_wr_addr = '0;
		imem_wr_data = '0;
		fetch_redirect = 1'b1;
		fetch_redirect_pc = '0;
		update_valid = 1'b0;
		update_pc = '0;
		update_dir = 1'b0;
		update_stall = 1'b0;
		ras_recover = 1'b0;
		ras_recover_index = '0;
		apply_reset();

		// fill while fetch sits at 0 and restart from reset afterwards
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			load_word(a * 4, fill_word(a[IMEM_AW-1:0]));
		end
		fetch_redirect = 1'b0;
		apply_reset();
		idle_cycles(SEQ_RUN);

		// single-cycle redirects over fall-through words
		for (int i = 0; i < REDIR_RUN; i++) begin
			fetch_redirect = ($urandom % 3 == 0);
			fetch_redirect_pc = $urandom & 32'hffff_fffc;
			@(negedge clk);
		end

		park_fetch(32'h100);
		// jumps where the 16-bit back step clears the byte offset
		load_word(32'h100, branch_word(SEL_IMM16, 1'b1, 1'b0, 16'h0040));
		load_word(32'h144, branch_word(SEL_IMM26, 1'b1, 1'b0, 16'h0080));
		load_word(32'h200, branch_word(SEL_IMM16, 1'b1, 1'b0, 16'hffe1));
		// nested call loop around 0x300
		load_word(32'h300, branch_word(SEL_IMM16, 1'b1, 1'b1, 16'h003c));
		load_word(32'h340, branch_word(SEL_IMM16, 1'b1, 1'b1, 16'h003c));
		load_word(32'h380, branch_word(SEL_RET, 1'b1, 1'b0, 16'h0000));
		load_word(32'h344, branch_word(SEL_RET, 1'b1, 1'b0, 16'h0000));
		load_word(32'h304, branch_word(SEL_IMM16, 1'b1, 1'b0, 16'hfff8));
		// conditional branch at 0x3c0 where both paths loop back
		load_word(32'h3c0, branch_word(SEL_IMM16, 1'b0, 1'b0, 16'h0010));
		load_word(32'h3c8, branch_word(SEL_IMM16, 1'b1, 1'b0, 16'hfff4));
		load_word(32'h3d4, branch_word(SEL_IMM16, 1'b1, 1'b0, 16'hffe8));
		resume_fetch();
		idle_cycles(JUMP_RUN);

		park_fetch(32'h300);
		resume_fetch();
		idle_cycles(CALL_RUN);
		park_fetch(32'h300);
		recover_stack(4'd9);
		resume_fetch();
		idle_cycles(CALL_RUN);
		park_fetch(32'h300);
		recover_stack(4'd0);
		resume_fetch();
		idle_cycles(CALL_RUN);

		// weights still zero here so the first pass goes taken
		park_fetch(32'h3c0);
		resume_fetch();
		// one entry driven into saturation
		for (int i = 0; i < BURST_RUN; i++) begin
			update_valid = 1'b1;
			update_pc = 32'h3c0;
			update_dir = 1'b1;
			@(negedge clk);
		end
		for (int i = 0; i < RAND_RUN; i++) begin
			update_valid = ($urandom % 2 == 1);
			update_pc = ($urandom % 2 == 1) ? 32'h3c0 : ($urandom & 32'hffff_fffc);
			update_dir = ($urandom % 2 == 1);
			@(negedge clk);
		end
		update_valid = 1'b0;
		idle_cycles(10);

		// stalled offers must leave no trace
		for (int i = 0; i < STALL_RUN; i++) begin
			update_valid = 1'b1;
			update_stall = ($urandom % 4 != 0);
			update_pc = 32'h3c0;
			update_dir = ($urandom % 2 == 1);
			@(negedge clk);
		end
		update_valid = 1'b0;
		update_stall = 1'b0;
		idle_cycles(20);

		total_errs = pc_errs + dir_errs + idx_errs + hs_errs;
		$display("mismatches fetch_pc %0d, pred_dir %0d, ras_index %0d, handshake %0d",
			pc_errs, dir_errs, idx_errs, hs_errs);
		if (total_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
hw/bp_pkg.sv
hw/ras_if.sv
hw/insn_mem.sv
hw/return_stack.sv
hw/perceptron_predictor.sv
hw/fetch_next_pc.sv
hw/bp_top.sv
testbench/tb_bp_top.sv

/* Bender.yml */
package:
  name: bp_fetch

sources:
  - files:
      - hw/bp_pkg.sv
      - hw/ras_if.sv
      - hw/insn_mem.sv
      - hw/return_stack.sv
      - hw/perceptron_predictor.sv
      - hw/fetch_next_pc.sv
      - hw/bp_top.sv
  - target: simulation
    files:
      - testbench/tb_bp_top.sv
